/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mac_ctrl_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/mac_ctrl_cfg.svh */
// Flow control configuration
`ifndef MAC_CTRL_CFG_SVH
`define MAC_CTRL_CFG_SVH

// Stream width and byte enables
`define MAC_DATA_W 64
`define MAC_KEEP_W 8

// Reserved multicast address for PAUSE frames
`define MAC_LFC_ETH_DST 48'h01_80_C2_00_00_01

// MAC control EtherType and the PAUSE opcode
`define MAC_CTRL_ETH_TYPE 16'h8808
`define MAC_LFC_OPCODE 16'h0001

// One quantum is 512 bit times, which is 8 clocks at 64 bits per beat
`define MAC_QUANTA_CYCLES 8

// Generated pause frame is 60 bytes, so the last beat carries 4 bytes
`define MAC_CTRL_BEATS 8

`endif

/* project.f */
+incdir+include
source/mac_ctrl_pkg.sv
source/mac_ctrl_tx.sv
source/mac_pause_ctrl_tx.sv
source/mac_ctrl_rx.sv
source/mac_pause_ctrl_rx.sv
source/mac_ctrl.sv
verification/mac_ctrl_tb.sv

/* source/mac_ctrl.sv */
// Link flow control top level
`timescale 1ns/1ns
`default_nettype none

module mac_ctrl
    import mac_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire mac_ctrl_cfg_t cfg,
    input  wire axis_beat_t    s_tx,
    input  wire logic          s_tx_valid,
    output logic               s_tx_ready,
    output axis_beat_t         m_tx,
    output logic               m_tx_valid,
    input  wire logic          m_tx_ready,
    input  wire rx_beat_t      s_rx,
    input  wire logic          s_rx_valid,
    output rx_beat_t           m_rx,
    output logic               m_rx_valid,
    input  wire logic          tx_lfc_req,
    input  wire logic          tx_pause_req,
    output logic               tx_pause_ack,
    output logic               rx_lfc_req,
    input  wire logic          rx_lfc_ack
);

    logic     mcf_valid;
    logic     mcf_ready;
    mcf_req_t mcf;
    logic     rx_mcf_valid;
    mcf_req_t rx_mcf;
    logic     tx_pause_req_int;
    logic     rx_lfc_ack_int;

    // A received pause can hold our own transmitter, which then acks the timer
    assign tx_pause_req_int = tx_pause_req || (cfg.pause_en && rx_lfc_req);
    assign rx_lfc_ack_int   = rx_lfc_ack || tx_pause_ack;

    mac_ctrl_tx mac_ctrl_tx_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .s_tx       (s_tx),
        .s_tx_valid (s_tx_valid),
        .s_tx_ready (s_tx_ready),
        .m_tx       (m_tx),
        .m_tx_valid (m_tx_valid),
        .m_tx_ready (m_tx_ready),
        .mcf_valid  (mcf_valid),
        .mcf        (mcf),
        .mcf_ready  (mcf_ready),
        .eth_src    (cfg.eth_src),
        .pause_req  (tx_pause_req_int),
        .pause_ack  (tx_pause_ack)
    );

    mac_pause_ctrl_tx mac_pause_ctrl_tx_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx_lfc_req (tx_lfc_req),
        .tx_lfc_en  (cfg.tx_lfc_en),
        .tx_quanta  (cfg.tx_quanta),
        .tx_refresh (cfg.tx_refresh),
        .mcf_valid  (mcf_valid),
        .mcf        (mcf),
        .mcf_ready  (mcf_ready)
    );

    mac_ctrl_rx mac_ctrl_rx_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .s_rx         (s_rx),
        .s_rx_valid   (s_rx_valid),
        .m_rx         (m_rx),
        .m_rx_valid   (m_rx_valid),
        .rx_mcf_valid (rx_mcf_valid),
        .rx_mcf       (rx_mcf)
    );

    mac_pause_ctrl_rx mac_pause_ctrl_rx_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx_mcf_valid (rx_mcf_valid),
        .rx_mcf       (rx_mcf),
        .rx_lfc_en    (cfg.rx_lfc_en),
        .rx_lfc_req   (rx_lfc_req),
        .rx_lfc_ack   (rx_lfc_ack_int)
    );

endmodule

`default_nettype wire

/* source/mac_ctrl_pkg.sv */
// Flow control types
`default_nettype none

`include "mac_ctrl_cfg.svh"

package mac_ctrl_pkg;

    // Byte 0 of a frame sits in data[7:0] of its first beat
    typedef struct packed {
        logic [`MAC_DATA_W-1:0] data;
        logic [`MAC_KEEP_W-1:0] keep;
        logic                   last;
    } axis_beat_t;

    typedef struct packed {
        axis_beat_t beat;
        logic       bad;   // MAC error flag, valid on the last beat
    } rx_beat_t;

    // Zero quanta is an XON
    typedef struct packed {
        logic [15:0] quanta;
    } mcf_req_t;

    typedef struct packed {
        logic [47:0] eth_src;     // Source address of generated frames
        logic [15:0] tx_quanta;
        logic [15:0] tx_refresh;  // Quanta between XOFF resends
        logic        tx_lfc_en;
        logic        rx_lfc_en;
        logic        pause_en;    // Received pause also holds the transmitter
    } mac_ctrl_cfg_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_CTRL
    } tx_sel_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PASS,
        RX_DROP
    } rx_class_e;

    typedef enum logic {
        LFC_OFF,
        LFC_XOFF_SENT
    } lfc_tx_e;

endpackage

`default_nettype wire

/* source/mac_ctrl_rx.sv */
// Receive control frame filter
`timescale 1ns/1ns
`default_nettype none

`include "mac_ctrl_cfg.svh"

module mac_ctrl_rx
    import mac_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire rx_beat_t s_rx,
    input  wire logic     s_rx_valid,
    output rx_beat_t      m_rx,
    output logic          m_rx_valid,
    output logic          rx_mcf_valid,
    output mcf_req_t      rx_mcf
);

    rx_class_e  state;  // Class of the frame whose beat sits in d1
    rx_beat_t   d1;
    logic       d1_valid;
    logic [1:0] in_idx;  // Input beat index, saturates at 3
    logic       is_pause;
    logic       dst_match;
    logic       type_match;
    logic       op_match;
    logic       is_ctrl;
    logic       drop_d1;

    // Beat 0 of the frame is in d1 while beat 1 is on the input
    always_comb begin
        dst_match  = {d1.beat.data[7:0], d1.beat.data[15:8], d1.beat.data[23:16],
                      d1.beat.data[31:24], d1.beat.data[39:32], d1.beat.data[47:40]}
                     == `MAC_LFC_ETH_DST;
        type_match = {s_rx.beat.data[39:32], s_rx.beat.data[47:40]} == `MAC_CTRL_ETH_TYPE;
        op_match   = {s_rx.beat.data[55:48], s_rx.beat.data[63:56]} == `MAC_LFC_OPCODE;
        is_ctrl    = d1_valid && !d1.beat.last && s_rx_valid && dst_match && type_match;
        drop_d1    = (state == RX_IDLE) ? is_ctrl : (state == RX_DROP);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= RX_IDLE;
            d1_valid     <= 1'b0;
            m_rx_valid   <= 1'b0;
            in_idx       <= '0;
            rx_mcf_valid <= 1'b0;
        end else begin
            d1_valid   <= s_rx_valid;
            m_rx_valid <= d1_valid && !drop_d1;

            if (d1_valid) begin
                if (d1.beat.last) begin
                    state <= RX_IDLE;
                end else if (state == RX_IDLE) begin
                    state <= is_ctrl ? RX_DROP : RX_PASS;
                end
            end

            if (s_rx_valid) begin
                if (s_rx.beat.last) begin
                    in_idx <= '0;
                end else if (in_idx != 2'd3) begin
                    in_idx <= in_idx + 2'd1;
                end
            end

            // A pause needs the quanta beat and a clean end of frame
            rx_mcf_valid <= s_rx_valid && s_rx.beat.last && !s_rx.bad &&
                            state == RX_DROP && is_pause && in_idx >= 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        d1   <= s_rx;
        m_rx <= d1;
        if (state == RX_IDLE && d1_valid) begin
            is_pause <= op_match;
        end
        if (s_rx_valid && in_idx == 2'd2) begin
            rx_mcf.quanta <= {s_rx.beat.data[7:0], s_rx.beat.data[15:8]};
        end
    end

    // Classification relies on back to back beats within a frame
    a_no_gap: assert property (@(posedge clk) disable iff (!arst_n)
        s_rx_valid && !s_rx.beat.last |=> s_rx_valid)
        else $error("gap inside a received frame");

endmodule

`default_nettype wire

/* source/mac_ctrl_tx.sv */
// Transmit control frame arbiter
`timescale 1ns/1ns
`default_nettype none

`include "mac_ctrl_cfg.svh"

module mac_ctrl_tx
    import mac_ctrl_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire axis_beat_t  s_tx,
    input  wire logic        s_tx_valid,
    output logic             s_tx_ready,
    output axis_beat_t       m_tx,
    output logic             m_tx_valid,
    input  wire logic        m_tx_ready,
    input  wire logic        mcf_valid,
    input  wire mcf_req_t    mcf,
    output logic             mcf_ready,
    input  wire logic [47:0] eth_src,
    input  wire logic        pause_req,
    output logic             pause_ack
);

    localparam int CNT_W = $clog2(`MAC_CTRL_BEATS);
    localparam int FRAME_BYTES = `MAC_KEEP_W * `MAC_CTRL_BEATS;
    localparam int HDR_BYTES = 18;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`MAC_CTRL_BEATS - 1);
    localparam logic [`MAC_KEEP_W-1:0] LAST_KEEP = 'h0F;

    tx_sel_e                    state;
    tx_sel_e                    state_next;
    logic [CNT_W-1:0]           beat_cnt;
    logic [15:0]                ctrl_quanta;
    logic [8*HDR_BYTES-1:0]     hdr_net;
    logic [8*FRAME_BYTES-1:0]   ctrl_bytes;
    axis_beat_t                 ctrl_beat;
    logic                       user_open;

    // Header fields in wire order, first byte in the top bits
    assign hdr_net = {`MAC_LFC_ETH_DST, eth_src, `MAC_CTRL_ETH_TYPE, `MAC_LFC_OPCODE,
                      ctrl_quanta};

    always_comb begin
        ctrl_bytes = '0;  // Padding up to 60 bytes stays zero
        for (int i = 0; i < HDR_BYTES; i++) begin
            ctrl_bytes[8*i +: 8] = hdr_net[8*(HDR_BYTES-1-i) +: 8];
        end
    end

    always_comb begin
        ctrl_beat.data = ctrl_bytes[`MAC_DATA_W*beat_cnt +: `MAC_DATA_W];
        ctrl_beat.last = (beat_cnt == LAST_BEAT);
        ctrl_beat.keep = ctrl_beat.last ? LAST_KEEP : '1;
    end

    // Output mux, the source is fixed for the whole frame
    always_comb begin
        m_tx       = s_tx;
        m_tx_valid = 1'b0;
        s_tx_ready = 1'b0;
        mcf_ready  = 1'b0;
        case (state)
            TX_DATA: begin
                m_tx_valid = s_tx_valid;
                s_tx_ready = m_tx_ready;
            end
            TX_CTRL: begin
                m_tx       = ctrl_beat;
                m_tx_valid = 1'b1;
                mcf_ready  = m_tx_ready && (beat_cnt == '0);  // Request is taken with beat 0
            end
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            TX_IDLE: begin
                if (mcf_valid) begin
                    state_next = TX_CTRL;  // Control frames win at a boundary
                end else if (s_tx_valid && !pause_req && !pause_ack) begin
                    state_next = TX_DATA;
                end
            end
            TX_DATA: if (s_tx_valid && m_tx_ready && s_tx.last) state_next = TX_IDLE;
            TX_CTRL: if (m_tx_ready && ctrl_beat.last) state_next = TX_IDLE;
            default: state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TX_IDLE;
            beat_cnt  <= '0;
            pause_ack <= 1'b0;
            user_open <= 1'b0;
        end else begin
            state <= state_next;
            if (state == TX_CTRL && m_tx_ready) begin
                beat_cnt <= ctrl_beat.last ? '0 : beat_cnt + 1'b1;
            end
            // Pause is granted only once no user frame is in flight
            pause_ack <= pause_req && (pause_ack || state == TX_IDLE);
            if (s_tx_valid && s_tx_ready) begin
                user_open <= !s_tx.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && mcf_valid) begin
            ctrl_quanta <= mcf.quanta;
        end
    end

    // The MAC sees a steady beat for as long as it stalls
    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        m_tx_valid && !m_tx_ready |=> m_tx_valid && $stable(m_tx))
        else $error("m_tx changed while stalled");

    a_ctrl_boundary: assert property (@(posedge clk) disable iff (!arst_n)
        state == TX_CTRL |-> !user_open)
        else $error("control beat inside a user frame");

endmodule

`default_nettype wire

/* source/mac_pause_ctrl_rx.sv */
// Receive pause timer
`timescale 1ns/1ns
`default_nettype none

`include "mac_ctrl_cfg.svh"

module mac_pause_ctrl_rx
    import mac_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     rx_mcf_valid,
    input  wire mcf_req_t rx_mcf,
    input  wire logic     rx_lfc_en,
    output logic          rx_lfc_req,
    input  wire logic     rx_lfc_ack
);

    localparam int CNT_W = 16 + $clog2(`MAC_QUANTA_CYCLES);

    logic [CNT_W-1:0] pause_cnt;
    logic             reload;

    assign reload = rx_mcf_valid && rx_lfc_en;  // Ignored entirely when disabled

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pause_cnt  <= '0;
            rx_lfc_req <= 1'b0;
        end else if (reload) begin
            // A new pause restarts the timer, XON clears it
            pause_cnt  <= CNT_W'(rx_mcf.quanta) * CNT_W'(`MAC_QUANTA_CYCLES);
            rx_lfc_req <= (rx_mcf.quanta != '0);
        end else if (rx_lfc_req && rx_lfc_ack) begin
            pause_cnt <= pause_cnt - 1'b1;  // Time only runs while the pause is honored
            if (pause_cnt == CNT_W'(1)) begin
                rx_lfc_req <= 1'b0;
            end
        end
    end

    // An expired timer stays at zero until the next pause frame
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        pause_cnt == '0 && !reload |=> pause_cnt == '0)
        else $error("pause counter wrapped below zero");

endmodule

`default_nettype wire

/* source/mac_pause_ctrl_tx.sv */
// Transmit pause request logic
`timescale 1ns/1ns
`default_nettype none

`include "mac_ctrl_cfg.svh"

module mac_pause_ctrl_tx
    import mac_ctrl_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        tx_lfc_req,
    input  wire logic        tx_lfc_en,
    input  wire logic [15:0] tx_quanta,
    input  wire logic [15:0] tx_refresh,
    output logic             mcf_valid,
    output mcf_req_t         mcf,
    input  wire logic        mcf_ready
);

    localparam int CNT_W = 16 + $clog2(`MAC_QUANTA_CYCLES);

    lfc_tx_e          state;
    logic [CNT_W-1:0] refresh_cnt;
    logic [CNT_W-1:0] refresh_limit;
    logic             refresh_hit;
    logic             slot_free;
    logic             send_xoff;
    logic             send_xon;

    assign refresh_limit = CNT_W'(tx_refresh) * CNT_W'(`MAC_QUANTA_CYCLES);
    assign refresh_hit   = (refresh_cnt >= refresh_limit);
    assign slot_free     = !mcf_valid || mcf_ready;  // A pending request is never replaced

    always_comb begin
        send_xoff = 1'b0;
        send_xon  = 1'b0;
        case (state)
            LFC_OFF: send_xoff = tx_lfc_req && tx_lfc_en && slot_free;
            LFC_XOFF_SENT: begin
                if (!tx_lfc_req) begin
                    send_xon = slot_free;
                end else begin
                    send_xoff = refresh_hit && slot_free;  // Keep the far end paused
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= LFC_OFF;
            mcf_valid   <= 1'b0;
            refresh_cnt <= '0;
        end else begin
            if (send_xoff || send_xon) begin
                mcf_valid <= 1'b1;
            end else if (mcf_ready) begin
                mcf_valid <= 1'b0;
            end

            if (send_xoff) begin
                state <= LFC_XOFF_SENT;
            end else if (send_xon) begin
                state <= LFC_OFF;
            end

            // Refresh period counts from the last XOFF request
            if (send_xoff) begin
                refresh_cnt <= '0;
            end else if (state == LFC_XOFF_SENT && !refresh_hit) begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send_xoff) begin
            mcf.quanta <= tx_quanta;
        end else if (send_xon) begin
            mcf.quanta <= '0;
        end
    end

    a_mcf_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mcf_valid && !mcf_ready |=> mcf_valid && $stable(mcf))
        else $error("pause request changed while waiting");

endmodule

`default_nettype wire

/* verification/mac_ctrl_tb.sv */
// PAUSE flow control testbench
`timescale 1ns/1ns
`default_nettype none

`include "mac_ctrl_cfg.svh"

module mac_ctrl_tb
    import mac_ctrl_pkg::*;
();

    logic          clk;
    logic          arst_n;
    mac_ctrl_cfg_t cfg;
    axis_beat_t    s_tx;
    logic          s_tx_valid;
    logic          s_tx_ready;
    axis_beat_t    m_tx;
    logic          m_tx_valid;
    logic          m_tx_ready;
    rx_beat_t      s_rx;
    logic          s_rx_valid;
    rx_beat_t      m_rx;
    logic          m_rx_valid;
    logic          tx_lfc_req;
    logic          tx_pause_req;
    logic          tx_pause_ack;
    logic          rx_lfc_req;
    logic          rx_lfc_ack;

    integer     seed = 32'h2559cd67;
    int         err_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    int         err_start;
    logic       bp_en;
    logic       rx_pass;     // Beat on s_rx belongs to a frame that must come out
    logic       rx_load;     // Last beat of a good pause frame
    logic [15:0] rx_load_q;

    logic        exp_d1_v;
    logic        exp_d2_v;
    rx_beat_t    exp_d1;
    rx_beat_t    exp_d2;
    logic        mcf_seen;
    logic [15:0] mcf_seen_q;
    logic [18:0] exp_cnt;
    logic        exp_req;

    axis_beat_t user_q[$];
    axis_beat_t ctrl_q[$];
    axis_beat_t user_head;
    axis_beat_t ctrl_head;
    logic       user_nonempty;
    logic       ctrl_nonempty;
    logic       frame_open;
    logic       frame_is_ctrl;
    logic       pick_ctrl;
    axis_beat_t exp_tx;

    mac_ctrl dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Beat idx of a 60 byte PAUSE frame built from the 802.3 layout
    function automatic axis_beat_t pause_beat(int idx, logic [47:0] src, logic [15:0] q);
        logic [7:0]  bytes [64];
        logic [47:0] dst = `MAC_LFC_ETH_DST;
        logic [15:0] etype = `MAC_CTRL_ETH_TYPE;
        logic [15:0] op = `MAC_LFC_OPCODE;
        axis_beat_t  b;
        foreach (bytes[j]) bytes[j] = 8'h00;
        for (int j = 0; j < 6; j++) begin
            bytes[j]     = dst[8*(5-j) +: 8];
            bytes[6 + j] = src[8*(5-j) +: 8];
        end
        bytes[12] = etype[15:8];
        bytes[13] = etype[7:0];
        bytes[14] = op[15:8];
        bytes[15] = op[7:0];
        bytes[16] = q[15:8];
        bytes[17] = q[7:0];
        for (int j = 0; j < 8; j++) b.data[8*j +: 8] = bytes[8*idx + j];
        b.last = (idx == `MAC_CTRL_BEATS - 1);
        b.keep = b.last ? 8'h0F : 8'hFF;
        return b;
    endfunction

    function automatic axis_beat_t random_beat(logic last);
        axis_beat_t b;
        b.data = {$random(seed), $random(seed)};
        b.keep = last ? (8'hFF >> ($unsigned($random(seed)) % 8)) : 8'hFF;
        b.last = last;
        return b;
    endfunction

    function automatic void update_heads();
        user_nonempty = (user_q.size() > 0);
        ctrl_nonempty = (ctrl_q.size() > 0);
        user_head     = user_nonempty ? user_q[0] : 'x;
        ctrl_head     = ctrl_nonempty ? ctrl_q[0] : 'x;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_rx_frame(int n, logic ctrl, logic [15:0] q, logic bad);
        for (int i = 0; i < n; i++) begin
            s_rx.beat  = ctrl ? pause_beat(i, 48'h02_00_5E_10_20_30, q) : random_beat(i == n-1);
            s_rx.bad   = (i == n-1) && bad;
            s_rx_valid = 1'b1;
            rx_pass    = !ctrl;
            rx_load    = ctrl && !bad && (i == n-1);
            rx_load_q  = q;
            next_cycle();
        end
        s_rx_valid = 1'b0;
        rx_pass    = 1'b0;
        rx_load    = 1'b0;
    endtask

    task automatic send_tx_frame(int n);
        axis_beat_t beats[$];
        logic       fire;
        for (int i = 0; i < n; i++) beats.push_back(random_beat(i == n-1));
        foreach (beats[i]) user_q.push_back(beats[i]);
        update_heads();
        foreach (beats[i]) begin
            s_tx       = beats[i];
            s_tx_valid = 1'b1;
            fire       = 1'b0;
            while (!fire) begin
                @(negedge clk);
                fire = s_tx_valid && s_tx_ready;  // Settled well away from both edges
                next_cycle();
            end
        end
        s_tx_valid = 1'b0;
    endtask

    task automatic push_ctrl_frame(logic [15:0] q);
        for (int i = 0; i < `MAC_CTRL_BEATS; i++) ctrl_q.push_back(pause_beat(i, cfg.eth_src, q));
        update_heads();
    endtask

    task automatic drain_tx();
        while (user_nonempty || ctrl_nonempty) next_cycle();
        wait_cycles(4);
    endtask

    task automatic finish_test(string name);
        if (err_count == err_start) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, err_count - err_start);
        end
        err_start = err_count;
    endtask

    // Reference for the receive path, two cycles of delay and the pause timer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_d1_v <= 1'b0;
            exp_d2_v <= 1'b0;
            mcf_seen <= 1'b0;
            exp_cnt  <= '0;
        end else begin
            exp_d1_v   <= s_rx_valid && rx_pass;
            exp_d1     <= s_rx;
            exp_d2_v   <= exp_d1_v;
            exp_d2     <= exp_d1;
            mcf_seen   <= rx_load && cfg.rx_lfc_en;
            mcf_seen_q <= rx_load_q;
            if (mcf_seen) begin
                exp_cnt <= 19'(mcf_seen_q) * `MAC_QUANTA_CYCLES;
            end else if (exp_cnt != '0 && (rx_lfc_ack || tx_pause_ack)) begin
                exp_cnt <= exp_cnt - 1'b1;
            end
        end
    end

    // The pause holds for as long as quanta time is left
    assign exp_req = (exp_cnt != '0);

    // A frame is identified as control by its first beat and keeps that source
    assign pick_ctrl = frame_open ? frame_is_ctrl
                                  : (ctrl_nonempty && m_tx.data == ctrl_head.data);
    assign exp_tx    = pick_ctrl ? ctrl_head : user_head;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_open    <= 1'b0;
            frame_is_ctrl <= 1'b0;
        end else if (m_tx_valid && m_tx_ready) begin
            if (pick_ctrl && ctrl_nonempty) begin
                void'(ctrl_q.pop_front());
            end else if (!pick_ctrl && user_nonempty) begin
                void'(user_q.pop_front());
            end else begin
                $display("Unexpected beat left m_tx at %0t with nothing queued", $time);
                err_count++;
            end
            update_heads();
            frame_open    <= !m_tx.last;
            frame_is_ctrl <= pick_ctrl;
        end
    end

    a_rx_valid: assert property (@(posedge clk) disable iff (!arst_n)
        m_rx_valid == exp_d2_v)
        else begin
            $display("CHECK FAILED t=%0t m_rx_valid expected %b actual %b",
                     $time, $sampled(exp_d2_v), $sampled(m_rx_valid));
            err_count++;
        end

    a_rx_beat: assert property (@(posedge clk) disable iff (!arst_n)
        m_rx_valid |-> m_rx == exp_d2)
        else begin
            $display("CHECK FAILED t=%0t m_rx expected %h actual %h",
                     $time, $sampled(exp_d2), $sampled(m_rx));
            err_count++;
        end

    a_lfc_req: assert property (@(posedge clk) disable iff (!arst_n)
        rx_lfc_req == exp_req)
        else begin
            $display("CHECK FAILED t=%0t rx_lfc_req expected %b actual %b",
                     $time, $sampled(exp_req), $sampled(rx_lfc_req));
            err_count++;
        end

    a_tx_beat: assert property (@(posedge clk) disable iff (!arst_n)
        m_tx_valid && m_tx_ready |-> m_tx == exp_tx)
        else begin
            $display("CHECK FAILED t=%0t m_tx expected %h actual %h",
                     $time, $sampled(exp_tx), $sampled(m_tx));
            err_count++;
        end

    // User data is taken only when it leaves at once as a user beat
    a_tx_ready: assert property (@(posedge clk) disable iff (!arst_n)
        s_tx_ready |-> m_tx_ready && !tx_pause_ack && !(m_tx_valid && pick_ctrl))
        else begin
            $display("CHECK FAILED t=%0t s_tx_ready expected %b actual %b",
                     $time, 1'b0, $sampled(s_tx_ready));
            err_count++;
        end

    a_pause_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_pause_ack && m_tx_valid |-> pick_ctrl)
        else begin
            $display("User beat offered on m_tx at %0t while the pause was acknowledged", $time);
            err_count++;
        end

    a_ack_boundary: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(tx_pause_ack) |-> !$past(frame_open))
        else begin
            $display("tx_pause_ack rose at %0t in the middle of a frame", $time);
            err_count++;
        end

    // Tests take under 2000 cycles together
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("Run stopped after %0d cycles because a test did not complete", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        m_tx_ready = 1'b1;
        forever begin
            next_cycle();
            m_tx_ready = bp_en ? $random(seed) % 4 != 0 : 1'b1;
        end
    end

    initial begin
        arst_n       = 1'b0;
        cfg          = '{eth_src: 48'h02_11_22_33_44_55, tx_quanta: 16'h0040,
                         tx_refresh: 16'hFFFF, tx_lfc_en: 1'b1, rx_lfc_en: 1'b1,
                         pause_en: 1'b0};
        s_tx         = '0;
        s_tx_valid   = 1'b0;
        s_rx         = '0;
        s_rx_valid   = 1'b0;
        tx_lfc_req   = 1'b0;
        tx_pause_req = 1'b0;
        rx_lfc_ack   = 1'b0;
        bp_en        = 1'b0;
        rx_pass      = 1'b0;
        rx_load      = 1'b0;
        rx_load_q    = '0;
        err_start    = 0;
        update_heads();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait_cycles(2);

        repeat (20) begin
            send_rx_frame(1 + $unsigned($random(seed)) % 10, 1'b0, '0, $random(seed) % 2 != 0);
            wait_cycles($unsigned($random(seed)) % 3);
        end
        wait_cycles(4);
        finish_test("rx pass-through");

        rx_lfc_ack = 1'b1;
        send_rx_frame(`MAC_CTRL_BEATS, 1'b1, 16'd5, 1'b0);
        while (!rx_lfc_req) next_cycle();
        while (rx_lfc_req) next_cycle();
        wait_cycles(2);
        send_rx_frame(`MAC_CTRL_BEATS, 1'b1, 16'd7, 1'b1);  // Bad frame must leave the timer idle
        wait_cycles(10);
        rx_lfc_ack = 1'b0;
        finish_test("rx pause drop and timer");

        bp_en = 1'b1;
        repeat (20) send_tx_frame(1 + $unsigned($random(seed)) % 10);
        drain_tx();
        finish_test("tx pass-through");

        fork
            repeat (4) send_tx_frame(1 + $unsigned($random(seed)) % 10);
            begin
                wait_cycles(6);
                tx_lfc_req = 1'b1;
                push_ctrl_frame(cfg.tx_quanta);
                wait_cycles(30);
                tx_lfc_req = 1'b0;
                push_ctrl_frame(16'h0000);  // XON
            end
        join
        drain_tx();
        finish_test("pause frame generation");

        cfg.pause_en = 1'b1;
        fork
            begin
                send_tx_frame(16);
                send_tx_frame(4);
                send_tx_frame(4);
            end
            begin
                wait_cycles(4);
                send_rx_frame(`MAC_CTRL_BEATS, 1'b1, 16'd3, 1'b0);
            end
        join
        while (rx_lfc_req) next_cycle();
        drain_tx();
        cfg.pause_en = 1'b0;
        finish_test("pause loop");

        if (user_q.size() != 0 || ctrl_q.size() != 0) begin
            $display("Expected transmit beats never left the DUT");
            err_count++;
        end
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
